// ==== verilog/ilm_fetch_settings.svh ====
// ILM fetch path settings for address widths and read queue depth.
`ifndef ILM_FETCH_SETTINGS_SVH
`define ILM_FETCH_SETTINGS_SVH

// Virtual fetch address width.
`define VALEN 32

// Top ILM byte-address bit, 2 KiB of 64-bit words.
`define ILM_AMSB 10

// In-flight read entries, at least read latency plus one.
`define ILM_QUEUE_DEPTH 3

`endif

// ==== verilog/ilm_fetch_pkg.sv ====
// ILM fetch types shared by the bridge, the ILM controller and the top level.
`include "ilm_fetch_settings.svh"

package ilm_fetch_pkg;

    typedef union packed {
        logic [63:0]       dword;               // Whole word.
        logic [3:0][15:0]  parcel;              // Instruction parcels, parcel 0 lowest.
    } fetch_word_u;

    typedef struct packed {
        logic              valid;
        logic              stall;
        logic [`VALEN-1:0] addr;
        logic              tag;
    } ifu_req_t;

    typedef struct packed {
        logic err;                              // Parity marker set on the word.
        logic more_pending;                     // Other reads still in flight.
    } fetch_status_t;

    typedef struct packed {
        logic [3:0]        valid;               // Parcel mask.
        fetch_word_u       rdata;
        logic              tag;
        fetch_status_t     status;
    } ifu_resp_t;

    typedef struct packed {
        logic                valid;
        logic                stall;
        logic [`ILM_AMSB:0]  addr;
        logic [2:0]          user;              // Parcel offset and tag.
    } ilm_a_t;

    typedef struct packed {
        logic        valid;
        fetch_word_u data;
        logic        err;
        logic [2:0]  user;
    } ilm_d_t;

    typedef struct packed {
        logic                  valid;
        logic [`ILM_AMSB-3:0]  addr;            // Word index.
        logic [63:0]           data;
        logic                  bad_parity;
    } ilm_wr_t;

endpackage

// ==== verilog/ilm_onehot_ptr.sv ====
// Rotating one-hot pointer that steps to the next entry on each advance.
`timescale 1ns/1ps

module ilm_onehot_ptr #(
    parameter int depth = 2
) (
    input  logic             core_clk,
    input  logic             core_reset_n,
    input  logic             advance,
    output logic [depth-1:0] ptr
);

    logic [depth-1:0] ptr_q;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            ptr_q <= {{(depth-1){1'b0}}, 1'b1};     // Entry 0.
        end else if (advance) begin
            ptr_q <= {ptr_q[depth-2:0], ptr_q[depth-1]};
        end
    end

    assign ptr = ptr_q;

endmodule

// ==== verilog/ilm_fetch_bridge.sv ====
// Fetch to ILM bridge with kill tracking, parcel alignment and response status.
`timescale 1ns/1ps
`include "ilm_fetch_settings.svh"

module ilm_fetch_bridge
    import ilm_fetch_pkg::*;
(
    input  logic      core_clk,
    input  logic      core_reset_n,
    input  logic      kill,
    input  ifu_req_t  fetch_req,
    output logic      req_ready,
    output ifu_resp_t fetch_resp,
    output ilm_a_t    ilm_a,
    input  logic      a_ready,
    input  ilm_d_t    ilm_d
);

    localparam int queue_depth = `ILM_QUEUE_DEPTH;

    logic [queue_depth-1:0] alloc_ptr;
    logic [queue_depth-1:0] retire_ptr;
    logic [queue_depth-1:0] alloc_mask;
    logic [queue_depth-1:0] killed;
    logic [queue_depth-1:0] in_flight;
    logic                   accept;
    logic                   retire;
    logic                   retire_killed;
    logic                   suppress;
    logic [1:0]             offset;
    fetch_word_u            aligned;

    ilm_onehot_ptr #(
        .depth(queue_depth)
    ) alloc_ptr_i (
        .core_clk    (core_clk),
        .core_reset_n(core_reset_n),
        .advance     (accept),
        .ptr         (alloc_ptr)
    );

    ilm_onehot_ptr #(
        .depth(queue_depth)
    ) retire_ptr_i (
        .core_clk    (core_clk),
        .core_reset_n(core_reset_n),
        .advance     (retire),
        .ptr         (retire_ptr)
    );

    // Command path.
    always_comb begin
        ilm_a.valid = fetch_req.valid;
        ilm_a.stall = fetch_req.stall;
        ilm_a.addr  = fetch_req.addr[`ILM_AMSB:0];
        ilm_a.user  = {fetch_req.addr[2:1], fetch_req.tag};
    end

    assign req_ready  = a_ready;
    assign accept     = ilm_a.valid & a_ready & ~ilm_a.stall;
    assign retire     = ilm_d.valid;
    assign alloc_mask = alloc_ptr & {queue_depth{accept}};

    // An entry allocated in the kill cycle stays live.
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            killed <= '0;
        end else begin
            killed <= (killed | {queue_depth{kill}}) & ~alloc_mask;
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            in_flight <= '0;
        end else begin
            for (int i = 0; i < queue_depth; i++) begin
                if (retire && retire_ptr[i]) begin
                    in_flight[i] <= 1'b0;
                end else if (alloc_mask[i]) begin
                    in_flight[i] <= 1'b1;
                end
            end
        end
    end

    // Response path.
    assign offset        = ilm_d.user[2:1];
    assign retire_killed = |(killed & retire_ptr);
    assign suppress      = retire_killed | kill;        // Same-cycle kill drops it too.

    always_comb begin
        aligned.dword = '0;                              // Zero fill above the word.
        for (int i = 0; i < 4; i++) begin
            if (i + offset < 4) begin
                aligned.parcel[i] = ilm_d.data.parcel[i + offset];
            end
        end
    end

    always_comb begin
        fetch_resp.valid               = (4'b1111 >> offset) & {4{retire & ~suppress}};
        fetch_resp.rdata               = aligned;
        fetch_resp.tag                 = ilm_d.user[0];
        fetch_resp.status.err          = ilm_d.err;
        fetch_resp.status.more_pending = |(in_flight & ~retire_ptr);
    end

endmodule

// ==== verilog/ilm_sram_ctrl.sv ====
// ILM storage with a load port and a two-stage pipelined read path.
`timescale 1ns/1ps
`include "ilm_fetch_settings.svh"

module ilm_sram_ctrl
    import ilm_fetch_pkg::*;
(
    input  logic    core_clk,
    input  logic    core_reset_n,
    input  ilm_a_t  ilm_a,
    output logic    a_ready,
    output ilm_d_t  ilm_d,
    input  ilm_wr_t ilm_wr
);

    localparam int words = 1 << (`ILM_AMSB - 2);

    logic [63:0]          mem [words];
    logic                 par [words];          // Stored parity-error markers.
    logic                 accept;
    logic                 s1_valid;
    logic [`ILM_AMSB-3:0] s1_addr;
    logic [2:0]           s1_user;
    logic                 s2_valid;
    logic [63:0]          s2_data;
    logic                 s2_err;
    logic [2:0]           s2_user;

    // Loads own the array port.
    assign a_ready = ~ilm_wr.valid;
    assign accept  = ilm_a.valid & a_ready & ~ilm_a.stall;

    always_ff @(posedge core_clk) begin
        if (ilm_wr.valid) begin
            mem[ilm_wr.addr] <= ilm_wr.data;
            par[ilm_wr.addr] <= ilm_wr.bad_parity;
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
        end
    end

    // Stage 1 holds the word index, stage 2 the array output.
    always_ff @(posedge core_clk) begin
        if (accept) begin
            s1_addr <= ilm_a.addr[`ILM_AMSB:3];
            s1_user <= ilm_a.user;
        end
        if (s1_valid) begin
            s2_data <= mem[s1_addr];
            s2_err  <= par[s1_addr];
            s2_user <= s1_user;
        end
    end

    always_comb begin
        ilm_d.valid      = s2_valid;
        ilm_d.data.dword = s2_data;
        ilm_d.err        = s2_err;
        ilm_d.user       = s2_user;
    end

endmodule

// ==== verilog/ilm_fetch_top.sv ====
// ILM fetch subsystem joining the fetch bridge to the ILM controller.
`timescale 1ns/1ps

module ilm_fetch_top
    import ilm_fetch_pkg::*;
(
    input  logic      core_clk,
    input  logic      core_reset_n,
    input  logic      kill,
    input  ifu_req_t  fetch_req,
    output logic      req_ready,
    output ifu_resp_t fetch_resp,
    input  ilm_wr_t   ilm_wr
);

    ilm_a_t ilm_a;
    logic   a_ready;
    ilm_d_t ilm_d;

    ilm_fetch_bridge bridge_i (
        .core_clk    (core_clk),
        .core_reset_n(core_reset_n),
        .kill        (kill),
        .fetch_req   (fetch_req),
        .req_ready   (req_ready),
        .fetch_resp  (fetch_resp),
        .ilm_a       (ilm_a),
        .a_ready     (a_ready),
        .ilm_d       (ilm_d)
    );

    ilm_sram_ctrl sram_i (
        .core_clk    (core_clk),
        .core_reset_n(core_reset_n),
        .ilm_a       (ilm_a),
        .a_ready     (a_ready),
        .ilm_d       (ilm_d),
        .ilm_wr      (ilm_wr)
    );

endmodule

// ==== sim/ilm_fetch_tb.sv ====
// Directed testbench for the ILM fetch path with a reference memory image and response model.
`timescale 1ns/1ps
`include "ilm_fetch_settings.svh"

module ilm_fetch_tb
    import ilm_fetch_pkg::*;
();

    localparam int words       = 1 << (`ILM_AMSB - 2);
    localparam int cycle_limit = 2000;          // Generous bound over the summed test length.

    typedef struct packed {
        logic [63:0] word;                      // Expected aligned word.
        logic [3:0]  mask;
        logic        tag;
        logic        err;
        logic        killed;
        logic [31:0] due;                       // Cycle the response must appear in.
    } expect_t;

    logic      core_clk;
    logic      core_reset_n;
    logic      kill;
    ifu_req_t  fetch_req;
    logic      req_ready;
    ifu_resp_t fetch_resp;
    ilm_wr_t   ilm_wr;

    logic [63:0] ref_mem [words];
    logic        ref_par [words];
    logic [7:0]  load_idx [16];
    expect_t     exp_q [$];
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    ilm_fetch_top dut_i (
        .core_clk    (core_clk),
        .core_reset_n(core_reset_n),
        .kill        (kill),
        .fetch_req   (fetch_req),
        .req_ready   (req_ready),
        .fetch_resp  (fetch_resp),
        .ilm_wr      (ilm_wr)
    );

    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    task automatic log_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic raise_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    // Valid parcels left after dropping the offset.
    function automatic logic [3:0] parcel_mask(input logic [1:0] off);
        case (off)
            2'd0:    return 4'b1111;
            2'd1:    return 4'b0111;
            2'd2:    return 4'b0011;
            default: return 4'b0001;
        endcase
    endfunction

    task automatic check_response(input expect_t exp, input logic pending);
        checks++;
        if (exp.killed) begin
            if (fetch_resp.valid !== 4'b0000) begin
                log_mismatch($sformatf("killed read returned mask %b", fetch_resp.valid));
            end
        end else if (fetch_resp.valid === 4'b0000) begin
            raise_error($sformatf("read due in cycle %0d returned no response", exp.due));
        end else begin
            if (fetch_resp.valid !== exp.mask) begin
                log_mismatch($sformatf("mask %b, expected %b", fetch_resp.valid, exp.mask));
            end
            if (fetch_resp.rdata.dword !== exp.word) begin
                log_mismatch($sformatf("data %h, expected %h", fetch_resp.rdata.dword, exp.word));
            end
            if (fetch_resp.tag !== exp.tag) begin
                log_mismatch($sformatf("tag %b, expected %b", fetch_resp.tag, exp.tag));
            end
            if (fetch_resp.status.err !== exp.err) begin
                log_mismatch($sformatf("err %b, expected %b", fetch_resp.status.err, exp.err));
            end
            if (fetch_resp.status.more_pending !== pending) begin
                log_mismatch($sformatf("more_pending %b, expected %b",
                                       fetch_resp.status.more_pending, pending));
            end
        end
    endtask

    // Inputs settle at the falling edge, so the rising edge sees stable values.
    always @(posedge core_clk) begin : monitor
        expect_t    head;
        expect_t    entry;
        logic [7:0] idx;
        logic [1:0] off;
        if (kill) begin
            for (int i = 0; i < exp_q.size(); i++) begin
                entry        = exp_q[i];
                entry.killed = 1'b1;
                exp_q[i]     = entry;
            end
        end
        if (exp_q.size() != 0) begin
            head = exp_q[0];
        end
        if (exp_q.size() != 0 && head.due == cycle) begin
            head = exp_q.pop_front();
            check_response(head, exp_q.size() != 0);
        end else if (fetch_resp.valid !== 4'b0000) begin
            raise_error($sformatf("response in cycle %0d with no read due", cycle));
        end
        // Ready drops only while a load is presented.
        if (fetch_req.valid && !ilm_wr.valid && !fetch_req.stall) begin
            idx          = fetch_req.addr[`ILM_AMSB:3];
            off          = fetch_req.addr[2:1];
            entry.word   = ref_mem[idx] >> (16 * off);
            entry.mask   = parcel_mask(off);
            entry.tag    = fetch_req.tag;
            entry.err    = ref_par[idx];
            entry.killed = 1'b0;
            entry.due    = cycle + 2;
            exp_q.push_back(entry);
        end
        cycle = cycle + 1;
    end

    task automatic write_word(input logic [7:0] idx, input logic [63:0] data, input logic bad);
        ilm_wr.valid      = 1'b1;
        ilm_wr.addr       = idx;
        ilm_wr.data       = data;
        ilm_wr.bad_parity = bad;
        ref_mem[idx]      = data;
        ref_par[idx]      = bad;
        @(negedge core_clk);
        ilm_wr.valid = 1'b0;
    endtask

    // Holds the request until it is accepted. Upper address bits are random.
    task automatic issue_fetch(input logic [7:0] idx, input logic [1:0] off, input logic tag);
        int tries;
        fetch_req.valid = 1'b1;
        fetch_req.stall = 1'b0;
        fetch_req.addr  = ($urandom() & 32'hFFFF_F800) | {idx, off, 1'b0};
        fetch_req.tag   = tag;
        tries = 0;
        @(posedge core_clk);
        while (!req_ready && tries < 8) begin
            tries++;
            @(posedge core_clk);
        end
        if (!req_ready) begin
            raise_error("fetch request was never accepted");
        end
        @(negedge core_clk);
    endtask

    task automatic end_fetch();
        fetch_req.valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge core_clk);
        end
    endtask

    task automatic close_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start);
        end
    endtask

    task automatic load_and_read();
        int start;
        start = errors;
        for (int i = 0; i < 16; i++) begin
            load_idx[i] = 8'(i * 16 + $urandom_range(0, 15));
            write_word(load_idx[i], {$urandom(), $urandom()}, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            issue_fetch(load_idx[i], 2'd0, 1'(i));
            end_fetch();
            wait_drained();
        end
        close_test("load and read back", start);
    endtask

    task automatic parcel_alignment();
        int start;
        start = errors;
        for (int off = 1; off < 4; off++) begin
            issue_fetch(load_idx[off + 2], 2'(off), 1'(off));
            end_fetch();
            wait_drained();
        end
        close_test("parcel alignment", start);
    endtask

    task automatic back_to_back();
        int start;
        start = errors;
        issue_fetch(load_idx[7], 2'd0, 1'b0);
        issue_fetch(load_idx[8], 2'd0, 1'b1);
        issue_fetch(load_idx[9], 2'd0, 1'b0);
        end_fetch();
        wait_drained();
        close_test("back-to-back and pending status", start);
    endtask

    task automatic kill_in_flight();
        int start;
        start = errors;
        issue_fetch(load_idx[10], 2'd0, 1'b0);
        issue_fetch(load_idx[11], 2'd0, 1'b1);
        kill = 1'b1;                            // Third read shares the kill cycle.
        issue_fetch(load_idx[12], 2'd1, 1'b1);
        kill = 1'b0;
        end_fetch();
        wait_drained();
        close_test("kill", start);
    endtask

    task automatic backpressure_and_stall();
        int          start;
        logic [63:0] data;
        start = errors;
        data  = {$urandom(), $urandom()};
        ilm_wr.valid      = 1'b1;
        ilm_wr.addr       = load_idx[3];
        ilm_wr.data       = data;
        ilm_wr.bad_parity = 1'b0;
        ref_mem[load_idx[3]] = data;
        ref_par[load_idx[3]] = 1'b0;
        fetch_req.valid = 1'b1;
        fetch_req.stall = 1'b0;
        fetch_req.addr  = {load_idx[3], 2'd0, 1'b0};
        fetch_req.tag   = 1'b1;
        @(posedge core_clk);
        checks++;
        if (req_ready !== 1'b0) begin
            log_mismatch("req_ready high while a write is presented");
        end
        @(negedge core_clk);
        ilm_wr.valid    = 1'b0;
        fetch_req.stall = 1'b1;
        repeat (2) @(negedge core_clk);
        fetch_req.stall = 1'b0;
        @(negedge core_clk);
        end_fetch();
        wait_drained();
        close_test("back-pressure and stall", start);
    endtask

    task automatic parity_error();
        int start;
        start = errors;
        write_word(load_idx[13], {$urandom(), $urandom()}, 1'b1);
        issue_fetch(load_idx[13], 2'd2, 1'b1);
        end_fetch();
        wait_drained();
        close_test("parity error", start);
    endtask

    initial begin
        void'($urandom(11));
        core_reset_n = 1'b0;
        kill         = 1'b0;
        fetch_req    = '0;
        ilm_wr       = '0;
        repeat (2) @(negedge core_clk);
        core_reset_n = 1'b1;
        @(negedge core_clk);
        load_and_read();
        parcel_alignment();
        back_to_back();
        kill_in_flight();
        backpressure_and_stall();
        parity_error();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (cycle >= cycle_limit);
        $display("timeout: run stopped after %0d cycles", cycle_limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== ilm_fetch_top.f ====
+incdir+verilog
verilog/ilm_fetch_pkg.sv
verilog/ilm_onehot_ptr.sv
verilog/ilm_fetch_bridge.sv
verilog/ilm_sram_ctrl.sv
verilog/ilm_fetch_top.sv
sim/ilm_fetch_tb.sv
